/* verilog/mbus_pkg.sv */
`default_nettype none

package mbus_pkg;

	// ----------------------------------------------------------------------
	// Main bus transaction fields
	// ----------------------------------------------------------------------

	// Word address, byte address bits 23:1
	typedef logic [23:1] mbus_addr_t;

	typedef logic [15:0] mbus_data_t;

	// One master request, held steady until dtack
	typedef struct packed {
		logic       valid;
		logic       rnw;
		// Upper and lower data strobes, active low
		logic [1:0] lane_n;
		mbus_addr_t addr;
		mbus_data_t wdata;
	} mbus_req_t;

	typedef struct packed {
		logic       dtack;
		mbus_data_t rdata;
	} mbus_rsp_t;

	// ----------------------------------------------------------------------
	// Bus owner and controller state
	// ----------------------------------------------------------------------

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_MAIN,
		SRC_SOUND,
		SRC_DMA
	} mbus_src_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SELECT,
		ST_RAM_READ,
		ST_ROM_READ,
		ST_FINISH
	} mbus_state_e;

endpackage

`default_nettype wire

/* verilog/map_pkg.sv */
`default_nettype none

package map_pkg;

	// ----------------------------------------------------------------------
	// Main CPU memory map
	// ----------------------------------------------------------------------

	// First top nibble past the cartridge ROM region
	localparam logic [3:0] ROM_LIMIT_HI = 4'hA;

	// Sound CPU control registers at A11100 and A11200
	localparam logic [11:0] CTRL_PAGE       = 12'hA11;
	localparam logic [3:0]  CTRL_BUSREQ_SEL = 4'h1;
	localparam logic [3:0]  CTRL_RESET_SEL  = 4'h2;

	// Cartridge bank registers, A130xx
	localparam logic [15:0] BANK_PAGE = 16'hA130;
	localparam int          BANK_COUNT = 8;
	localparam int          BANK_W     = 5;

	// Banking only on carts larger than 2 MB (word address)
	localparam logic [22:0] BANK_THRESHOLD = 23'h100000;

	// Open bus value after reset (a NOP opcode)
	localparam logic [15:0] NO_DATA_RESET = 16'h4E71;

	// ----------------------------------------------------------------------
	// Sound CPU window and work RAM
	// ----------------------------------------------------------------------

	localparam int         SOUND_BAR_W    = 9;
	// Bank window register at 6000-60FF
	localparam logic [6:0] SOUND_BAR_PAGE = 7'h60;

	// 64 KB of work RAM as 32K words
	localparam int RAM_WORDS_W = 15;

endpackage

`default_nettype wire

/* verilog/work_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module work_ram #(
	parameter int ADDR_W = map_pkg::RAM_WORDS_W
) (
	input  logic                  MCLK,
	input  logic [ADDR_W-1:0]     addr,
	input  mbus_pkg::mbus_data_t  wdata,
	input  logic [1:0]            we_n,
	output mbus_pkg::mbus_data_t  q
);

	// Lane 1 is the upper byte, lane 0 the lower
	for (genvar i = 0; i < 2; i++) begin : g_lane
		logic [7:0] mem [0:(1 << ADDR_W) - 1];
		logic [7:0] q_lane;

		always_ff @(posedge MCLK) begin
			if (!we_n[i])
				mem[addr] <= wdata[i*8 +: 8];
			// Read returns the old byte on a write cycle
			q_lane <= mem[addr];
		end

		assign q[i*8 +: 8] = q_lane;
	end

endmodule

`default_nettype wire

/* verilog/cart_mapper.sv */
`default_nettype none
`timescale 1ns/1ps

module cart_mapper (
	input  logic                  MCLK,
	input  logic                  reset,
	input  mbus_pkg::mbus_addr_t  addr,
	input  mbus_pkg::mbus_data_t  wdata,
	input  mbus_pkg::mbus_addr_t  rom_size,
	input  logic                  bank_wr,
	input  logic                  rom_start,
	output logic                  rom_done,
	output logic [24:1]           rom_addr,
	output logic                  rom_req,
	input  logic                  rom_ack
);

	logic [map_pkg::BANK_W-1:0] bank [map_pkg::BANK_COUNT];
	logic banking_ok;
	logic banked;
	logic pending;

	// SSF2 style banking needs a cart above 2 MB
	assign banking_ok = rom_size > map_pkg::BANK_THRESHOLD;

	// ----------------------------------------------------------------------
	// Bank registers and ROM request toggle
	// ----------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			banked <= 1'b0;
			pending <= 1'b0;
			rom_req <= 1'b0;
			// Identity mapping out of reset
			for (int i = 0; i < map_pkg::BANK_COUNT; i++)
				bank[i] <= map_pkg::BANK_W'(i);
		end else begin
			// Register 0 is fixed
			if (bank_wr && banking_ok && addr[3:1] != 3'd0) begin
				bank[addr[3:1]] <= wdata[map_pkg::BANK_W-1:0];
				banked <= 1'b1;
			end

			if (rom_start) begin
				rom_req <= ~rom_req;
				pending <= 1'b1;
			end else if (rom_done) begin
				pending <= 1'b0;
			end
		end
	end

	// Access over once the memory side echoes the toggle
	assign rom_done = pending & (rom_req == rom_ack);

	// ----------------------------------------------------------------------
	// ROM address, 512 KB slots when banked
	// ----------------------------------------------------------------------

	always_comb begin
		if (banked)
			rom_addr = {1'b0, bank[addr[21:19]], addr[18:1]};
		else
			rom_addr = {1'b0, addr};
	end

endmodule

`default_nettype wire

/* verilog/mbus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module mbus_arbiter (
	input  logic                  MCLK,
	input  logic                  reset,
	input  mbus_pkg::mbus_req_t   main_req,
	input  mbus_pkg::mbus_req_t   sound_req,
	input  mbus_pkg::mbus_req_t   dma_req,
	output mbus_pkg::mbus_rsp_t   main_rsp,
	output mbus_pkg::mbus_rsp_t   sound_rsp,
	output mbus_pkg::mbus_rsp_t   dma_rsp,
	input  logic                  bus_idle,
	output mbus_pkg::mbus_req_t   bus_req,
	output mbus_pkg::mbus_src_e   bus_src,
	input  mbus_pkg::mbus_rsp_t   bus_rsp
);

	mbus_pkg::mbus_src_e gnt;
	mbus_pkg::mbus_src_e sel;
	mbus_pkg::mbus_req_t snd_bus_req;
	mbus_pkg::mbus_req_t dma_bus_req;
	logic [map_pkg::SOUND_BAR_W-1:0] bar;
	logic       snd_local;
	logic       snd_bar_wr;
	logic       snd_ack;
	logic [7:0] snd_byte;

	// ----------------------------------------------------------------------
	// Request shaping per master
	// ----------------------------------------------------------------------

	// Sound: only 8000-FFFF reaches the main bus, through the bank window
	always_comb begin
		snd_bus_req = sound_req;
		snd_bus_req.valid = sound_req.valid & sound_req.addr[15];
		snd_bus_req.addr = {bar, sound_req.addr[14:1]};
		snd_bus_req.wdata = {sound_req.wdata[7:0], sound_req.wdata[7:0]};
	end

	// DMA always reads full words
	always_comb begin
		dma_bus_req = dma_req;
		dma_bus_req.rnw = 1'b1;
		dma_bus_req.lane_n = 2'b00;
		dma_bus_req.wdata = '0;
	end

	// ----------------------------------------------------------------------
	// Fixed priority grant, only while the controller is idle
	// ----------------------------------------------------------------------

	always_comb begin
		sel = gnt;
		if (gnt == mbus_pkg::SRC_NONE && bus_idle) begin
			if (main_req.valid)
				sel = mbus_pkg::SRC_MAIN;
			else if (snd_bus_req.valid)
				sel = mbus_pkg::SRC_SOUND;
			else if (dma_bus_req.valid)
				sel = mbus_pkg::SRC_DMA;
		end
	end

	always_comb begin
		case (sel)
			mbus_pkg::SRC_MAIN:  bus_req = main_req;
			mbus_pkg::SRC_SOUND: bus_req = snd_bus_req;
			mbus_pkg::SRC_DMA:   bus_req = dma_bus_req;
			default:             bus_req = '0;
		endcase
	end

	assign bus_src = sel;

	// Held until the owner drops valid
	always_ff @(posedge MCLK) begin
		if (reset)
			gnt <= mbus_pkg::SRC_NONE;
		else
			gnt <= bus_req.valid ? sel : mbus_pkg::SRC_NONE;
	end

	// ----------------------------------------------------------------------
	// Sound accesses answered here: window writes and unmapped space
	// ----------------------------------------------------------------------

	assign snd_local = sound_req.valid & ~sound_req.addr[15];
	assign snd_bar_wr = snd_local & ~snd_ack & ~sound_req.rnw &
		(sound_req.addr[15:8] == {1'b0, map_pkg::SOUND_BAR_PAGE});

	always_ff @(posedge MCLK) begin
		if (reset) begin
			snd_ack <= 1'b0;
			bar <= '0;
		end else begin
			snd_ack <= snd_local;
			// One bit per write, shifted in from the top
			if (snd_bar_wr)
				bar <= {sound_req.wdata[0], bar[map_pkg::SOUND_BAR_W-1:1]};
		end
	end

	// ----------------------------------------------------------------------
	// Response routing
	// ----------------------------------------------------------------------

	// Odd byte sits on the lower lane
	assign snd_byte = sound_req.lane_n[1] ? bus_rsp.rdata[7:0] : bus_rsp.rdata[15:8];

	assign main_rsp.dtack = (gnt == mbus_pkg::SRC_MAIN) & bus_rsp.dtack;
	assign main_rsp.rdata = bus_rsp.rdata;

	assign dma_rsp.dtack = (gnt == mbus_pkg::SRC_DMA) & bus_rsp.dtack;
	assign dma_rsp.rdata = bus_rsp.rdata;

	assign sound_rsp.dtack = snd_ack | ((gnt == mbus_pkg::SRC_SOUND) & bus_rsp.dtack);
	assign sound_rsp.rdata = snd_ack ? 16'hFFFF : {8'hFF, snd_byte};

endmodule

`default_nettype wire

/* verilog/mbus_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module mbus_ctrl (
	input  logic                  MCLK,
	input  logic                  reset,
	input  mbus_pkg::mbus_req_t   bus_req,
	input  mbus_pkg::mbus_src_e   bus_src,
	output mbus_pkg::mbus_rsp_t   bus_rsp,
	output logic                  bus_idle,
	input  mbus_pkg::mbus_addr_t  rom_size,
	output logic                  rom_start,
	input  logic                  rom_done,
	input  mbus_pkg::mbus_data_t  rom_data,
	output logic                  bank_wr,
	output logic [1:0]            ram_we_n,
	input  mbus_pkg::mbus_data_t  ram_q,
	output logic                  sound_busrq_n,
	output logic                  sound_reset_n
);

	mbus_pkg::mbus_state_e state;
	mbus_pkg::mbus_data_t  data;
	mbus_pkg::mbus_data_t  open_bus;
	mbus_pkg::mbus_data_t  dflt_data;
	logic dtack;
	logic busrq_n;
	logic snd_rst_n;

	logic rom_region;
	logic rom_in_size;
	logic ctrl_hit;
	logic bank_hit;
	logic ram_hit;
	logic ctrl_bit;
	logic main_read;
	logic in_select;

	// ----------------------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------------------

	// 000000-9FFFFF
	assign rom_region = bus_req.addr[23:20] < map_pkg::ROM_LIMIT_HI;
	assign rom_in_size = bus_req.addr < rom_size;

	// A11100 and A11200 only
	assign ctrl_hit = (bus_req.addr[23:12] == map_pkg::CTRL_PAGE) &&
		(bus_req.addr[11:8] == map_pkg::CTRL_BUSREQ_SEL ||
		 bus_req.addr[11:8] == map_pkg::CTRL_RESET_SEL) &&
		(bus_req.addr[7:1] == 7'd0);

	assign bank_hit = bus_req.addr[23:8] == map_pkg::BANK_PAGE;

	// E00000-FFFFFF
	assign ram_hit = &bus_req.addr[23:21];

	// Readback of the written state
	assign ctrl_bit = (bus_req.addr[11:8] == map_pkg::CTRL_BUSREQ_SEL) ? ~busrq_n : snd_rst_n;

	// Sound sees FF on floating lines
	assign dflt_data = (bus_src == mbus_pkg::SRC_SOUND) ? 16'hFFFF : open_bus;

	assign main_read = (bus_src == mbus_pkg::SRC_MAIN) & bus_req.rnw;
	assign in_select = state == mbus_pkg::ST_SELECT;

	// ----------------------------------------------------------------------
	// Strobes to the targets
	// ----------------------------------------------------------------------

	assign rom_start = in_select & rom_region & rom_in_size;
	assign bank_wr = in_select & bank_hit & ~bus_req.rnw;
	assign ram_we_n = (in_select && ram_hit && !bus_req.rnw) ? bus_req.lane_n : 2'b11;

	// ----------------------------------------------------------------------
	// Bus state machine
	// ----------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= mbus_pkg::ST_IDLE;
			dtack <= 1'b0;
			open_bus <= map_pkg::NO_DATA_RESET;
			busrq_n <= 1'b1;
			snd_rst_n <= 1'b0;
		end else begin
			case (state)
				mbus_pkg::ST_IDLE:
					if (bus_req.valid)
						state <= mbus_pkg::ST_SELECT;

				mbus_pkg::ST_SELECT: begin
					state <= mbus_pkg::ST_FINISH;
					if (rom_region) begin
						if (rom_in_size)
							state <= mbus_pkg::ST_ROM_READ;
					end else if (ctrl_hit) begin
						// Control bits live on the upper byte
						if (!bus_req.rnw && !bus_req.lane_n[1]) begin
							if (bus_req.addr[11:8] == map_pkg::CTRL_BUSREQ_SEL)
								busrq_n <= ~bus_req.wdata[8];
							else
								snd_rst_n <= bus_req.wdata[8];
						end
					end else if (ram_hit) begin
						state <= mbus_pkg::ST_RAM_READ;
					end
				end

				mbus_pkg::ST_RAM_READ: begin
					if (main_read)
						open_bus <= ram_q;
					state <= mbus_pkg::ST_FINISH;
				end

				mbus_pkg::ST_ROM_READ:
					if (rom_done) begin
						if (main_read)
							open_bus <= rom_data;
						state <= mbus_pkg::ST_FINISH;
					end

				mbus_pkg::ST_FINISH:
					// Raise dtack, then hold it until the master lets go
					if (!dtack) begin
						dtack <= 1'b1;
					end else if (!bus_req.valid) begin
						dtack <= 1'b0;
						state <= mbus_pkg::ST_IDLE;
					end

				default:
					state <= mbus_pkg::ST_IDLE;
			endcase
		end
	end

	// Read data capture
	always_ff @(posedge MCLK) begin
		case (state)
			mbus_pkg::ST_SELECT:
				if (rom_region && !rom_in_size)
					data <= '0;
				else if (ctrl_hit)
					data <= {open_bus[15:9], ctrl_bit, open_bus[7:0]};
				else
					data <= dflt_data;
			mbus_pkg::ST_RAM_READ:
				data <= ram_q;
			mbus_pkg::ST_ROM_READ:
				if (rom_done)
					data <= rom_data;
			default: ;
		endcase
	end

	assign bus_rsp.dtack = dtack;
	assign bus_rsp.rdata = data;
	assign bus_idle = state == mbus_pkg::ST_IDLE;
	assign sound_busrq_n = busrq_n;
	assign sound_reset_n = snd_rst_n;

endmodule

`default_nettype wire

/* verilog/md_bus_top.sv */
`default_nettype none
`timescale 1ns/1ps

module md_bus_top (
	input  logic                  MCLK,
	input  logic                  reset,
	input  mbus_pkg::mbus_req_t   main_req,
	input  mbus_pkg::mbus_req_t   sound_req,
	input  mbus_pkg::mbus_req_t   dma_req,
	output mbus_pkg::mbus_rsp_t   main_rsp,
	output mbus_pkg::mbus_rsp_t   sound_rsp,
	output mbus_pkg::mbus_rsp_t   dma_rsp,
	input  mbus_pkg::mbus_addr_t  rom_size,
	output logic [24:1]           rom_addr,
	output logic                  rom_req,
	input  logic                  rom_ack,
	input  mbus_pkg::mbus_data_t  rom_data,
	output logic                  sound_busrq_n,
	output logic                  sound_reset_n
);

	mbus_pkg::mbus_req_t  bus_req;
	mbus_pkg::mbus_src_e  bus_src;
	mbus_pkg::mbus_rsp_t  bus_rsp;
	mbus_pkg::mbus_data_t ram_q;
	logic       bus_idle;
	logic       rom_start;
	logic       rom_done;
	logic       bank_wr;
	logic [1:0] ram_we_n;

	mbus_arbiter u_arbiter (
		.MCLK      (MCLK),
		.reset     (reset),
		.main_req  (main_req),
		.sound_req (sound_req),
		.dma_req   (dma_req),
		.main_rsp  (main_rsp),
		.sound_rsp (sound_rsp),
		.dma_rsp   (dma_rsp),
		.bus_idle  (bus_idle),
		.bus_req   (bus_req),
		.bus_src   (bus_src),
		.bus_rsp   (bus_rsp)
	);

	mbus_ctrl u_ctrl (
		.MCLK          (MCLK),
		.reset         (reset),
		.bus_req       (bus_req),
		.bus_src       (bus_src),
		.bus_rsp       (bus_rsp),
		.bus_idle      (bus_idle),
		.rom_size      (rom_size),
		.rom_start     (rom_start),
		.rom_done      (rom_done),
		.rom_data      (rom_data),
		.bank_wr       (bank_wr),
		.ram_we_n      (ram_we_n),
		.ram_q         (ram_q),
		.sound_busrq_n (sound_busrq_n),
		.sound_reset_n (sound_reset_n)
	);

	// Address and write data come straight off the granted request
	cart_mapper u_mapper (
		.MCLK      (MCLK),
		.reset     (reset),
		.addr      (bus_req.addr),
		.wdata     (bus_req.wdata),
		.rom_size  (rom_size),
		.bank_wr   (bank_wr),
		.rom_start (rom_start),
		.rom_done  (rom_done),
		.rom_addr  (rom_addr),
		.rom_req   (rom_req),
		.rom_ack   (rom_ack)
	);

	work_ram #(
		.ADDR_W (map_pkg::RAM_WORDS_W)
	) u_ram (
		.MCLK  (MCLK),
		.addr  (bus_req.addr[map_pkg::RAM_WORDS_W:1]),
		.wdata (bus_req.wdata),
		.we_n  (ram_we_n),
		.q     (ram_q)
	);

endmodule

`default_nettype wire

/* dv/md_bus_props.sv */
`default_nettype none
`timescale 1ns/1ps

module md_bus_props (
	input logic       MCLK,
	input logic       reset,
	input logic [2:0] req_valid,
	input logic [2:0] rsp_dtack,
	input logic       bus_idle,
	input logic       rom_req,
	input logic       rom_ack
);

	// Only one master is answered at a time
	a_one_dtack: assert property (@(posedge MCLK) disable iff (reset)
		$onehot0(rsp_dtack))
		else $error("more than one master sees dtack");

	// New ROM request only after the last one was echoed
	a_rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		!$stable(rom_req) |-> $past(rom_req) == $past(rom_ack))
		else $error("rom_req toggled while a ROM access was in flight");

	// Controller stays parked with no requester
	a_idle_hold: assert property (@(posedge MCLK) disable iff (reset)
		(req_valid == 3'b000 && bus_idle) |=> bus_idle)
		else $error("bus left idle with no master valid");

endmodule

bind md_bus_top md_bus_props u_props (
	.MCLK      (MCLK),
	.reset     (reset),
	.req_valid ({main_req.valid, sound_req.valid, dma_req.valid}),
	.rsp_dtack ({main_rsp.dtack, sound_rsp.dtack, dma_rsp.dtack}),
	.bus_idle  (bus_idle),
	.rom_req   (rom_req),
	.rom_ack   (rom_ack)
);

`default_nettype wire

/* dv/tb_md_bus.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_md_bus;

	localparam int TIMEOUT = 100;

	logic MCLK;
	logic reset;
	mbus_pkg::mbus_req_t  main_req;
	mbus_pkg::mbus_req_t  sound_req;
	mbus_pkg::mbus_req_t  dma_req;
	mbus_pkg::mbus_rsp_t  main_rsp;
	mbus_pkg::mbus_rsp_t  sound_rsp;
	mbus_pkg::mbus_rsp_t  dma_rsp;
	mbus_pkg::mbus_addr_t rom_size;
	logic [24:1]          rom_addr;
	logic                 rom_req;
	logic                 rom_ack;
	mbus_pkg::mbus_data_t rom_data;
	logic                 sound_busrq_n;
	logic                 sound_reset_n;

	integer      seed;
	logic [24:1] rom_seen;
	int          checks = 0;
	int          errors = 0;

	md_bus_top uut (.*);

	initial begin
		MCLK = 1'b0;
		forever #10 MCLK = ~MCLK;
	end

	// ----------------------------------------------------------------------
	// Cartridge ROM model
	// ----------------------------------------------------------------------

	// Contents derived from the word address
	function automatic mbus_pkg::mbus_data_t rom_word(input logic [24:1] a);
		return a[16:1] ^ 16'h5A5A;
	endfunction

	// Echoes each request toggle after 1 to 6 cycles
	initial begin : rom_model
		int unsigned lat;
		seed = 32'ha30bb3bd;
		rom_ack = 1'b0;
		rom_data = '0;
		rom_seen = '0;
		forever begin
			@(posedge MCLK);
			#2;
			if (!reset && rom_req !== rom_ack) begin
				rom_seen = rom_addr;
				lat = 1 + ($unsigned($random(seed)) % 6);
				repeat (lat - 1) begin
					@(posedge MCLK);
					#2;
				end
				rom_data = rom_word(rom_seen);
				rom_ack = rom_req;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------

	task automatic check_data(input string name, input mbus_pkg::mbus_data_t exp,
		input mbus_pkg::mbus_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [24:1] exp,
		input logic [24:1] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// ----------------------------------------------------------------------
	// Master drivers
	// ----------------------------------------------------------------------

	function automatic mbus_pkg::mbus_rsp_t rsp_of(input mbus_pkg::mbus_src_e src);
		case (src)
			mbus_pkg::SRC_MAIN:  return main_rsp;
			mbus_pkg::SRC_SOUND: return sound_rsp;
			default:             return dma_rsp;
		endcase
	endfunction

	task automatic drive_req(input mbus_pkg::mbus_src_e src, input mbus_pkg::mbus_req_t req);
		case (src)
			mbus_pkg::SRC_MAIN:  main_req = req;
			mbus_pkg::SRC_SOUND: sound_req = req;
			default:             dma_req = req;
		endcase
	endtask

	// Hold the request until dtack, then release and wait for dtack to clear
	task automatic run_access(input mbus_pkg::mbus_src_e src, input string name,
		input mbus_pkg::mbus_req_t req, output mbus_pkg::mbus_data_t rdata,
		output time t_ack);
		mbus_pkg::mbus_rsp_t rsp;
		int n;
		@(posedge MCLK);
		#2;
		drive_req(src, req);
		n = 0;
		rsp = rsp_of(src);
		while (!rsp.dtack && n < TIMEOUT) begin
			@(posedge MCLK);
			#2;
			rsp = rsp_of(src);
			n++;
		end
		if (!rsp.dtack) begin
			errors++;
			$display("%s: no dtack from bus within %0d cycles", name, TIMEOUT);
		end
		rdata = rsp.rdata;
		t_ack = $time;
		req.valid = 1'b0;
		drive_req(src, req);
		n = 0;
		while (rsp.dtack && n < TIMEOUT) begin
			@(posedge MCLK);
			#2;
			rsp = rsp_of(src);
			n++;
		end
		if (rsp.dtack) begin
			errors++;
			$display("%s: dtack stayed high after valid was dropped", name);
		end
	endtask

	task automatic main_access(input string name, input logic rnw, input logic [23:0] byte_addr,
		input logic [1:0] lane_n, input mbus_pkg::mbus_data_t wdata,
		output mbus_pkg::mbus_data_t rdata, output time t_ack);
		mbus_pkg::mbus_req_t req;
		req.valid = 1'b1;
		req.rnw = rnw;
		req.lane_n = lane_n;
		req.addr = byte_addr[23:1];
		req.wdata = wdata;
		run_access(mbus_pkg::SRC_MAIN, name, req, rdata, t_ack);
	endtask

	// Byte address bit 0 goes into the strobes
	task automatic sound_access(input string name, input logic rnw, input logic [15:0] byte_addr,
		input logic [7:0] wbyte, output mbus_pkg::mbus_data_t rdata);
		mbus_pkg::mbus_req_t req;
		time t_ack;
		req.valid = 1'b1;
		req.rnw = rnw;
		req.lane_n = byte_addr[0] ? 2'b10 : 2'b01;
		req.addr = {8'h00, byte_addr[15:1]};
		req.wdata = {8'h00, wbyte};
		run_access(mbus_pkg::SRC_SOUND, name, req, rdata, t_ack);
	endtask

	task automatic dma_access(input string name, input logic [23:0] byte_addr,
		output mbus_pkg::mbus_data_t rdata, output time t_ack);
		mbus_pkg::mbus_req_t req;
		req.valid = 1'b1;
		req.rnw = 1'b1;
		req.lane_n = 2'b00;
		req.addr = byte_addr[23:1];
		req.wdata = '0;
		run_access(mbus_pkg::SRC_DMA, name, req, rdata, t_ack);
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------

	task automatic test_reset_values();
		mbus_pkg::mbus_data_t rd;
		time t;
		check_bit("reset sound_busrq_n", 1'b1, sound_busrq_n);
		check_bit("reset sound_reset_n", 1'b0, sound_reset_n);
		check_bit("reset rom_req", 1'b0, rom_req);
		check_bit("reset main dtack", 1'b0, main_rsp.dtack);
		check_bit("reset sound dtack", 1'b0, sound_rsp.dtack);
		check_bit("reset dma dtack", 1'b0, dma_rsp.dtack);
		// No RAM or ROM read yet so the open bus still holds the NOP
		main_access("open bus after reset", 1'b1, 24'hB00000, 2'b00, '0, rd, t);
		check_data("open bus after reset", 16'h4E71, rd);
	endtask

	task automatic test_work_ram();
		mbus_pkg::mbus_data_t rd;
		time t;
		main_access("ram write E00010", 1'b0, 24'hE00010, 2'b00, 16'h1234, rd, t);
		main_access("ram write E00012", 1'b0, 24'hE00012, 2'b00, 16'h5678, rd, t);
		// Upper strobe only so the low byte keeps 34
		main_access("ram write upper", 1'b0, 24'hE00010, 2'b01, 16'hABCD, rd, t);
		main_access("ram read E00010", 1'b1, 24'hE00010, 2'b00, '0, rd, t);
		check_data("ram read E00010", 16'hAB34, rd);
		main_access("ram read E00012", 1'b1, 24'hE00012, 2'b00, '0, rd, t);
		check_data("ram read E00012", 16'h5678, rd);
	endtask

	task automatic test_rom_mapping();
		mbus_pkg::mbus_data_t rd;
		logic [24:1] exp_addr;
		time t;
		exp_addr = 24'h080246 >> 1;
		main_access("rom identity read", 1'b1, 24'h080246, 2'b00, '0, rd, t);
		check_addr("rom identity addr", exp_addr, rom_seen);
		check_data("rom identity data", rom_word(exp_addr), rd);
		// Slot 1 (byte bits 3:1 of F3) now points at 512 KB page 5
		main_access("bank write", 1'b0, 24'hA130F3, 2'b10, 16'h0005, rd, t);
		exp_addr = (24'd5 * 24'h080000 + 24'h000246) >> 1;
		main_access("rom banked read", 1'b1, 24'h080246, 2'b00, '0, rd, t);
		check_addr("rom banked addr", exp_addr, rom_seen);
		check_data("rom banked data", rom_word(exp_addr), rd);
	endtask

	task automatic test_sound_control();
		mbus_pkg::mbus_data_t rd;
		time t;
		// Bus request still released after reset
		main_access("busreq idle read", 1'b1, 24'hA11100, 2'b00, '0, rd, t);
		check_bit("busreq idle readback", 1'b0, rd[8]);
		main_access("busreq write", 1'b0, 24'hA11100, 2'b00, 16'h0100, rd, t);
		check_bit("busreq asserted", 1'b0, sound_busrq_n);
		main_access("busreq read", 1'b1, 24'hA11100, 2'b00, '0, rd, t);
		check_bit("busreq readback", 1'b1, rd[8]);
		main_access("sound reset write", 1'b0, 24'hA11200, 2'b00, 16'h0100, rd, t);
		check_bit("sound reset released", 1'b1, sound_reset_n);
	endtask

	task automatic test_sound_window();
		mbus_pkg::mbus_data_t rd;
		mbus_pkg::mbus_data_t exp;
		logic [8:0]  window;
		logic [24:1] exp_addr;
		window = 9'h003;
		// LSB first as each write shifts in at the top
		for (int i = 0; i < 9; i++)
			sound_access("window write", 1'b0, 16'h6000, {7'd0, window[i]}, rd);
		exp_addr = {1'b0, window, 14'h0000};
		exp = rom_word(exp_addr);
		sound_access("window odd read", 1'b1, 16'h8001, 8'h00, rd);
		check_addr("window rom addr", exp_addr, rom_seen);
		check_data("window odd read", {8'hFF, exp[7:0]}, rd);
		sound_access("window even read", 1'b1, 16'h8000, 8'h00, rd);
		check_data("window even read", {8'hFF, exp[15:8]}, rd);
	endtask

	task automatic test_open_bus();
		mbus_pkg::mbus_data_t rd;
		time t;
		main_access("open bus ram read", 1'b1, 24'hE00012, 2'b00, '0, rd, t);
		check_data("open bus ram read", 16'h5678, rd);
		main_access("open bus unmapped", 1'b1, 24'hB00000, 2'b00, '0, rd, t);
		check_data("open bus unmapped", 16'h5678, rd);
		sound_access("sound unmapped read", 1'b1, 16'h0000, 8'h00, rd);
		check_data("sound unmapped read", 16'hFFFF, rd);
	endtask

	task automatic test_priority();
		mbus_pkg::mbus_data_t rd_main;
		mbus_pkg::mbus_data_t rd_dma;
		time t_main;
		time t_dma;
		fork
			main_access("priority main", 1'b1, 24'hE00012, 2'b00, '0, rd_main, t_main);
			dma_access("priority dma", 24'hE00010, rd_dma, t_dma);
		join
		check_bit("main served first", 1'b1, t_main < t_dma);
		check_data("priority main data", 16'h5678, rd_main);
		check_data("priority dma data", 16'hAB34, rd_dma);
	endtask

	// ----------------------------------------------------------------------
	// Sequence
	// ----------------------------------------------------------------------

	initial begin
		reset = 1'b1;
		main_req = '0;
		sound_req = '0;
		dma_req = '0;
		// 4 MB cart large enough for banking
		rom_size = 23'h200000;
		repeat (4) @(posedge MCLK);
		#2;
		reset = 1'b0;

		test_reset_values();
		test_work_ram();
		test_rom_mapping();
		test_sound_control();
		test_sound_window();
		test_open_bus();
		test_priority();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
verilog/mbus_pkg.sv
verilog/map_pkg.sv
verilog/work_ram.sv
verilog/cart_mapper.sv
verilog/mbus_arbiter.sv
verilog/mbus_ctrl.sv
verilog/md_bus_top.sv
dv/md_bus_props.sv
dv/tb_md_bus.sv

/* run_sim.sh */
#!/bin/sh
# Build the md_bus testbench with Verilator and run it

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_md_bus \
	-Mdir "$OBJ" -o tb_md_bus -f src.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/tb_md_bus" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "Testbench reported failure, see $LOG"
	exit 1
fi

echo "No failure reported in $LOG"
exit 0
